//--- ahbRam.sv
`timescale 1ns/1ns

module ahbRam import uncorePkg::*; (
  input  logic    HCLK,
  input  logic    arstN,
  input  ahbReqT  req,
  input  dataT    hWData,
  input  logic    hSel,
  input  logic    hReadyIn,
  output ahbRespT resp
);

  // storage, one entry per 32 bit word
  dataT mem [ramWords];

  logic                accept;
  logic                writeD;
  logic [ramAddrW-1:0] wordD;
  logic [1:0]          laneD;
  sizeT                sizeD;
  logic [3:0]          byteEn;

  //////////////////////////////
  // address phase capture
  //////////////////////////////

  // transfer taken when selected, active and the bus is not stalled
  assign accept = hSel & hReadyIn & req.hTrans[1];

  // only the write flag is control state
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      writeD <= 1'b0;
    end else if (hReadyIn) begin
      writeD <= accept & req.hWrite;
    end
  end

  // address and size of the pending data phase
  always_ff @(posedge HCLK) begin
    if (accept) begin
      wordD <= req.hAddr[ramAddrW+1:2];
      laneD <= req.hAddr[1:0];
      sizeD <= req.hSize;
    end
  end

  //////////////////////////////
  // lane select
  //////////////////////////////

  // little endian, byte k lives in hWData[8k+7:8k]
  always_comb begin
    case (sizeD)
      3'd0:    byteEn = 4'b0001 << laneD;
      3'd1:    byteEn = 4'b0011 << {laneD[1], 1'b0};
      default: byteEn = 4'b1111;
    endcase
  end

  //////////////////////////////
  // data phase
  //////////////////////////////

  // write lands on the edge that closes the data phase
  // hWData is valid in the data phase cycle
  always_ff @(posedge HCLK) begin
    if (writeD) begin
      for (int i = 0; i < 4; i++) begin
        if (byteEn[i]) begin
          mem[wordD][8*i +: 8] <= hWData[8*i +: 8];
        end
      end
    end
  end

  // asynchronous read of the captured word
  // a write one transfer earlier is already in the array here
  assign resp.hRData = mem[wordD];

  // zero wait states, never errors
  assign resp.hReady = 1'b1;
  assign resp.hResp  = 1'b0;

endmodule

//--- ahbTimer.sv
`timescale 1ns/1ns

module ahbTimer import uncorePkg::*; (
  input  logic        HCLK,
  input  logic        arstN,
  input  ahbReqT      req,
  input  dataT        hWData,
  input  logic        hSel,
  input  logic        hReadyIn,
  output ahbRespT     resp,
  output logic [63:0] mtime,
  output logic        timerInt,
  output logic        swInt
);

  logic        accept;
  // first and second cycle of a data phase
  logic        firstD;
  logic        secondD;
  logic        writeD;
  logic [15:0] offD;
  logic        wrEn;
  logic [63:0] mtimecmp;
  logic        msip;
  dataT        rdMux;
  dataT        rdData;

  //////////////////////////////
  // bus handshake
  //////////////////////////////

  assign accept = hSel & hReadyIn & req.hTrans[1];

  // one wait state on every transfer
  // hReady low in firstD, high in secondD
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      firstD  <= 1'b0;
      secondD <= 1'b0;
      writeD  <= 1'b0;
    end else begin
      firstD  <= accept;
      secondD <= firstD;
      if (accept) begin
        writeD <= req.hWrite;
      end
    end
  end

  // register offset inside the 64 KiB window
  always_ff @(posedge HCLK) begin
    if (accept) begin
      offD <= req.hAddr[15:0];
    end
  end

  // writes commit on the edge that ends the data phase
  assign wrEn = secondD & writeD;

  //////////////////////////////
  // timer registers
  //////////////////////////////

  // mtime counts hclk cycles, a write replaces one half
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      mtime <= '0;
    end else if (wrEn && offD == mtimeLoOff) begin
      mtime <= {mtime[63:32], hWData};
    end else if (wrEn && offD == mtimeHiOff) begin
      mtime <= {hWData, mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // compare starts at all ones so no interrupt out of reset
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      mtimecmp <= '1;
      msip     <= 1'b0;
    end else if (wrEn) begin
      case (offD)
        mtimecmpLoOff: mtimecmp[31:0]  <= hWData;
        mtimecmpHiOff: mtimecmp[63:32] <= hWData;
        msipOff:       msip            <= hWData[0];
        default:       ;
      endcase
    end
  end

  assign timerInt = (mtime >= mtimecmp);
  assign swInt    = msip;

  //////////////////////////////
  // read path
  //////////////////////////////

  // unlisted offsets read as zero
  always_comb begin
    case (offD)
      msipOff:       rdMux = {31'b0, msip};
      mtimecmpLoOff: rdMux = mtimecmp[31:0];
      mtimecmpHiOff: rdMux = mtimecmp[63:32];
      mtimeLoOff:    rdMux = mtime[31:0];
      mtimeHiOff:    rdMux = mtime[63:32];
      default:       rdMux = '0;
    endcase
  end

  // sampled at the end of the wait state, presented in the second cycle
  always_ff @(posedge HCLK) begin
    if (firstD) begin
      rdData <= rdMux;
    end
  end

  assign resp.hRData = rdData;
  assign resp.hReady = ~firstD;
  assign resp.hResp  = 1'b0;

endmodule

//--- busFabric.sv
`timescale 1ns/1ns

module busFabric import uncorePkg::*; (
  input  logic    HCLK,
  input  logic    arstN,
  input  ahbReqT  req,
  input  ahbRespT ramResp,
  input  ahbRespT timerResp,
  output logic    hSelRam,
  output logic    hSelTimer,
  output dataT    hRData,
  output logic    hReady,
  output logic    hResp
);

  logic     active;
  logic     unmapped;
  // owner of the current data phase
  logic     ownRamD;
  logic     ownTimerD;
  logic     ownNoneD;
  fabStateT state;
  fabStateT stateNext;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // plain range compare on the address phase
  assign hSelRam   = (req.hAddr >= ramBase) && (req.hAddr < ramBase + ramRange);
  assign hSelTimer = (req.hAddr >= timerBase) && (req.hAddr < timerBase + timerRange);

  assign active   = req.hTrans[1];
  assign unmapped = active & ~hSelRam & ~hSelTimer;

  //////////////////////////////
  // data phase select
  //////////////////////////////

  // moves only when the bus accepts a new address phase
  // an idle phase leaves no owner at all
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      ownRamD   <= 1'b0;
      ownTimerD <= 1'b0;
      ownNoneD  <= 1'b0;
    end else if (hReady) begin
      ownRamD   <= active & hSelRam;
      ownTimerD <= active & hSelTimer;
      ownNoneD  <= unmapped;
    end
  end

  //////////////////////////////
  // error responder
  //////////////////////////////

  // fabIdle with ownNoneD is the first error cycle, fabErr the second
  always_comb begin
    stateNext = state;
    case (state)
      fabIdle: if (ownNoneD) stateNext = fabErr;
      fabErr:  stateNext = fabIdle;
      default: stateNext = fabIdle;
    endcase
  end

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      state <= fabIdle;
    end else begin
      state <= stateNext;
    end
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb begin
    if (ownRamD) begin
      hRData = ramResp.hRData;
      hReady = ramResp.hReady;
      hResp  = ramResp.hResp;
    end else if (ownTimerD) begin
      hRData = timerResp.hRData;
      hReady = timerResp.hReady;
      hResp  = timerResp.hResp;
    end else if (ownNoneD) begin
      // two cycle ERROR, stall first then complete
      hRData = '0;
      hReady = (state == fabErr);
      hResp  = 1'b1;
    end else begin
      // idle data phase, okay with no wait
      hRData = '0;
      hReady = 1'b1;
      hResp  = 1'b0;
    end
  end

endmodule

//--- project.f
uncorePkg.sv
ahbRam.sv
ahbTimer.sv
busFabric.sv
uncore.sv
tbUncore.sv

//--- runSim.sh
#!/usr/bin/env bash
# build and run the uncore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module tbUncore -f project.f \
  || { echo "build failed"; exit 1; }

simOut="$(./obj_dir/VtbUncore)" || { echo "$simOut"; echo "simulation aborted"; exit 1; }
echo "$simOut"

echo "$simOut" | grep -qx "No errors" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

//--- tbUncore.sv
`timescale 1ns/1ns

module tbUncore import uncorePkg::*; ();

  localparam int resetCycles  = 16;
  localparam int ramInitWords = 64;
  localparam int randomOps    = 200;
  // about ten times the roughly 400 cycle sequence
  localparam int maxCycles    = 4000;

  typedef enum {regionRam, regionTimer, regionNone} regionT;

  logic        HCLK;
  logic        arstN;
  ahbReqT      req;
  dataT        hWData;
  dataT        hRData;
  logic        hReady;
  logic        hResp;
  logic [63:0] mtime;
  logic        timerInt;
  logic        swInt;

  integer seed;
  int     errCount;
  int     cycleCount;
  // write data of the pending address phase, driven once it is accepted
  dataT   heldWData;

  // reference model
  dataT        refMem [ramWords];
  logic        refMsip;
  logic [63:0] refCmp;
  // expected mtime, one count per cycle after reset release
  logic [63:0] refTime;

  // bus monitor state
  logic   dpValid;
  ahbReqT dpReq;
  int     dpCycles;
  dataT   lastRData;

  uncore i_uncore (
    .HCLK     (HCLK),
    .arstN    (arstN),
    .req      (req),
    .hWData   (hWData),
    .hRData   (hRData),
    .hReady   (hReady),
    .hResp    (hResp),
    .mtime    (mtime),
    .timerInt (timerInt),
    .swInt    (swInt)
  );

  //////////////////////////////
  // clock and timeout
  //////////////////////////////

  initial begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < maxCycles) begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("timeout: test sequence did not finish within %0d cycles", maxCycles);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // aligned regions let the upper address bits decide
  function automatic regionT regionOf(input addrT addr);
    if (addr[31:12] == ramBase[31:12]) begin
      return regionRam;
    end
    if (addr[31:16] == timerBase[31:16]) begin
      return regionTimer;
    end
    return regionNone;
  endfunction

  function automatic addrT timerAddr(input logic [15:0] off);
    return timerBase | {16'b0, off};
  endfunction

  // init pattern where every address bit shows up in the word
  function automatic dataT fillWord(input addrT addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
  endfunction

  // one cycle for ram and two for timer and error responses
  function automatic int expCycles(input addrT addr);
    return (regionOf(addr) == regionRam) ? 1 : 2;
  endfunction

  function automatic logic readChecked(input addrT addr);
    if (regionOf(addr) == regionRam) begin
      return 1'b1;
    end
    if (regionOf(addr) == regionNone) begin
      return 1'b0;
    end
    // mtime moves every cycle so its bus reads get no exact value
    return (addr[15:0] != mtimeLoOff) && (addr[15:0] != mtimeHiOff);
  endfunction

  function automatic dataT expRead(input addrT addr);
    dataT val;
    val = '0;
    if (regionOf(addr) == regionRam) begin
      val = refMem[addr[11:2]];
    end else if (regionOf(addr) == regionTimer) begin
      case (addr[15:0])
        msipOff:       val = {31'b0, refMsip};
        mtimecmpLoOff: val = refCmp[31:0];
        mtimecmpHiOff: val = refCmp[63:32];
        default:       val = '0;
      endcase
    end
    return val;
  endfunction

  // little endian lanes with byte k in data[8k+7:8k]
  task automatic applyWrite(input addrT addr, input sizeT size, input dataT data);
    logic [3:0] lanes;
    case (size)
      3'd0:    lanes = 4'b0001 << addr[1:0];
      3'd1:    lanes = addr[1] ? 4'b1100 : 4'b0011;
      default: lanes = 4'b1111;
    endcase
    if (regionOf(addr) == regionRam) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          refMem[addr[11:2]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end else if (regionOf(addr) == regionTimer) begin
      case (addr[15:0])
        msipOff:       refMsip = data[0];
        mtimecmpLoOff: refCmp[31:0] = data;
        mtimecmpHiOff: refCmp[63:32] = data;
        default:       ;
      endcase
    end
  endtask

  task automatic checkVal(input string name, input dataT expVal, input dataT actVal);
    if (actVal !== expVal) begin
      errCount++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
    end
  endtask

  //////////////////////////////
  // bus monitor
  //////////////////////////////

  // samples mid cycle when all bus signals are settled
  always @(negedge HCLK) begin
    if (!arstN) begin
      dpValid = 1'b0;
      refMsip = 1'b0;
      refCmp  = '1;
      refTime = '0;
    end else begin
      // free running time counter on the top level port
      checkVal("mtimeLo", refTime[31:0], mtime[31:0]);
      checkVal("mtimeHi", refTime[63:32], mtime[63:32]);
      refTime = refTime + 64'd1;
      if (dpValid) begin
        dpCycles++;
        // error responses keep hResp high in both cycles
        checkVal("hResp", dataT'(regionOf(dpReq.hAddr) == regionNone), dataT'(hResp));
        if (hReady) begin
          checkVal("data phase cycles", dataT'(expCycles(dpReq.hAddr)), dataT'(dpCycles));
          if (dpReq.hWrite) begin
            applyWrite(dpReq.hAddr, dpReq.hSize, hWData);
          end else begin
            lastRData = hRData;
            if (readChecked(dpReq.hAddr)) begin
              checkVal("hRData", expRead(dpReq.hAddr), hRData);
            end
          end
        end
      end else begin
        // idle data phase
        checkVal("hReady", 32'd1, dataT'(hReady));
        checkVal("hResp", 32'd0, dataT'(hResp));
      end
      // address phase taken on the coming edge
      if (hReady) begin
        dpValid  = req.hTrans[1];
        dpReq    = req;
        dpCycles = 0;
      end
    end
  end

  //////////////////////////////
  // manager tasks
  //////////////////////////////

  // puts a new address phase on the bus as the previous one is accepted
  // returns mid cycle once hReady is high and the next call hits the accept edge
  task automatic present(input ahbReqT nextReq, input dataT nextWData);
    @(posedge HCLK);
    req       <= nextReq;
    hWData    <= heldWData;
    heldWData = nextWData;
    @(negedge HCLK);
    while (!hReady) begin
      @(posedge HCLK);
      @(negedge HCLK);
    end
  endtask

  task automatic ahbWrite(input addrT addr, input sizeT size, input dataT data);
    ahbReqT r;
    r.hAddr  = addr;
    r.hWrite = 1'b1;
    r.hSize  = size;
    r.hTrans = 2'b10;
    present(r, data);
  endtask

  task automatic ahbRead(input addrT addr);
    ahbReqT r;
    r.hAddr  = addr;
    r.hWrite = 1'b0;
    r.hSize  = 3'd2;
    r.hTrans = 2'b10;
    present(r, '0);
  endtask

  task automatic idle();
    present('0, '0);
  endtask

  // closes the last data phase and lets its write land
  task automatic drain();
    idle();
    idle();
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    dataT       rnd;
    dataT       data;
    addrT       addr;
    dataT       firstTime;
    logic [2:0] op;
    seed      = 32'h989d_e510;
    errCount  = 0;
    heldWData = '0;
    arstN     <= 1'b0;
    req       <= '0;
    hWData    <= '0;
    repeat (resetCycles) @(posedge HCLK);
    arstN <= 1'b1;

    // state out of reset
    @(negedge HCLK);
    checkVal("hReady", 32'd1, dataT'(hReady));
    checkVal("hResp", 32'd0, dataT'(hResp));
    checkVal("timerInt", 32'd0, dataT'(timerInt));
    checkVal("swInt", 32'd0, dataT'(swInt));
    repeat (4) idle();

    // ram gets a known window first and then mixed random traffic inside it
    for (int i = 0; i < ramInitWords; i++) begin
      addr = ramBase + (addrT'(i) << 2);
      ahbWrite(addr, 3'd2, fillWord(addr));
    end
    for (int i = 0; i < randomOps; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      op   = rnd[30:28];
      case (op)
        3'd3:             ahbWrite(ramBase | {24'b0, rnd[7:1], 1'b0}, 3'd1, data);
        3'd4:             ahbWrite(ramBase | {24'b0, rnd[7:0]}, 3'd0, data);
        3'd5, 3'd6, 3'd7: ahbRead(ramBase | {24'b0, rnd[7:2], 2'b00});
        default:          ahbWrite(ramBase | {24'b0, rnd[7:2], 2'b00}, 3'd2, data);
      endcase
    end
    drain();

    // software interrupt bit
    ahbWrite(timerAddr(msipOff), 3'd2, 32'd1);
    drain();
    checkVal("swInt", 32'd1, dataT'(swInt));
    ahbRead(timerAddr(msipOff));
    ahbWrite(timerAddr(msipOff), 3'd2, 32'd0);
    drain();
    checkVal("swInt", 32'd0, dataT'(swInt));
    ahbRead(timerAddr(msipOff));
    drain();

    // compare register and timer interrupt
    ahbWrite(timerAddr(mtimecmpLoOff), 3'd2, 32'hFFFF_FFFF);
    ahbWrite(timerAddr(mtimecmpHiOff), 3'd2, 32'hFFFF_FFFF);
    drain();
    checkVal("timerInt", 32'd0, dataT'(timerInt));
    ahbWrite(timerAddr(mtimecmpLoOff), 3'd2, 32'd0);
    ahbWrite(timerAddr(mtimecmpHiOff), 3'd2, 32'd0);
    ahbRead(timerAddr(mtimecmpHiOff));
    drain();
    checkVal("timerInt", 32'd1, dataT'(timerInt));
    ahbRead(timerAddr(mtimeLoOff));
    drain();
    firstTime = lastRData;
    ahbRead(timerAddr(mtimeLoOff));
    drain();
    if (lastRData <= firstTime) begin
      errCount++;
      $display("ERROR at %0t ns: mtimeLo did not increase, first %h, then %h",
               $time, firstTime, lastRData);
    end

    // unmapped space where the manager goes idle after each ERROR
    ahbRead(32'h4000_0000);
    idle();
    ahbWrite(32'h1000_0010, 3'd2, 32'hDEAD_BEEF);
    idle();
    ahbRead(ramBase | 32'h0000_0040);
    drain();

    // back to back transfers alternating between subordinates
    for (int i = 0; i < 8; i++) begin
      addr = ramBase + (addrT'(i) << 4);
      data = $random(seed);
      ahbWrite(addr, 3'd2, data);
      ahbWrite(timerAddr(msipOff), 3'd2, {31'b0, data[0]});
      ahbRead(addr);
      ahbRead(timerAddr(msipOff));
    end
    drain();

    $display("run complete: %0d errors", errCount);
    if (errCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- uncore.sv
`timescale 1ns/1ns

module uncore import uncorePkg::*; (
  input  logic        HCLK,
  input  logic        arstN,
  // manager port
  input  ahbReqT      req,
  input  dataT        hWData,
  output dataT        hRData,
  output logic        hReady,
  output logic        hResp,
  // timer outputs
  output logic [63:0] mtime,
  output logic        timerInt,
  output logic        swInt
);

  logic    hSelRam;
  logic    hSelTimer;
  ahbRespT ramResp;
  ahbRespT timerResp;

  //////////////////////////////
  // decode and response combine
  //////////////////////////////

  busFabric i_busFabric (
    .HCLK      (HCLK),
    .arstN     (arstN),
    .req       (req),
    .ramResp   (ramResp),
    .timerResp (timerResp),
    .hSelRam   (hSelRam),
    .hSelTimer (hSelTimer),
    .hRData    (hRData),
    .hReady    (hReady),
    .hResp     (hResp)
  );

  //////////////////////////////
  // subordinates
  //////////////////////////////

  // both see the shared bus hReady as hReadyIn
  ahbRam i_ahbRam (
    .HCLK     (HCLK),
    .arstN    (arstN),
    .req      (req),
    .hWData   (hWData),
    .hSel     (hSelRam),
    .hReadyIn (hReady),
    .resp     (ramResp)
  );

  ahbTimer i_ahbTimer (
    .HCLK     (HCLK),
    .arstN    (arstN),
    .req      (req),
    .hWData   (hWData),
    .hSel     (hSelTimer),
    .hReadyIn (hReady),
    .resp     (timerResp),
    .mtime    (mtime),
    .timerInt (timerInt),
    .swInt    (swInt)
  );

endmodule

//--- uncorePkg.sv
package uncorePkg;

  //////////////////////////////
  // bus field types
  //////////////////////////////

  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;
  // hsize encoding, 0 byte, 1 half, 2 word
  typedef logic [2:0]  sizeT;
  // bit 1 set marks nonseq or seq
  typedef logic [1:0]  transT;

  // address phase as driven by the manager
  typedef struct packed {
    addrT  hAddr;
    logic  hWrite;
    sizeT  hSize;
    transT hTrans;
  } ahbReqT;

  // data phase reply of one subordinate
  typedef struct packed {
    dataT hRData;
    logic hReady;
    logic hResp;
  } ahbRespT;

  //////////////////////////////
  // address map
  //////////////////////////////

  localparam addrT ramBase  = 32'h8000_0000;
  localparam addrT ramRange = 32'h0000_1000;
  localparam int   ramWords = 1024;
  // word index width inside the ram
  localparam int   ramAddrW = $clog2(ramWords);

  localparam addrT timerBase  = 32'h0200_0000;
  localparam addrT timerRange = 32'h0001_0000;
  // clint style register offsets
  localparam logic [15:0] msipOff       = 16'h0000;
  localparam logic [15:0] mtimecmpLoOff = 16'h4000;
  localparam logic [15:0] mtimecmpHiOff = 16'h4004;
  localparam logic [15:0] mtimeLoOff    = 16'hBFF8;
  localparam logic [15:0] mtimeHiOff    = 16'hBFFC;

  // fabric error responder
  typedef enum logic {fabIdle, fabErr} fabStateT;

endpackage
